//--- ciPkg.sv
`default_nettype none

package ciPkg;

  // Processor data path width, shared by both operands and the result.
  localparam int dataWidth = 32;

  typedef logic [dataWidth-1:0] ciWord_t;
  typedef logic [7:0]           ciId_t;

  // Each instruction unit decodes its own number from ciN.
  localparam ciId_t swapByteId  = 8'd1;
  localparam ciId_t delayId     = 8'd6;
  localparam ciId_t grayscaleId = 8'd9;
  localparam ciId_t profileId   = 8'd12;

  localparam int numRequesters = 5;

  typedef logic [numRequesters-1:0] busRequest_t; // Index 4 has the highest priority.

  typedef logic [1:0] profileSel_t; // Selector value 3 reads as zero.

endpackage

`default_nettype wire

//--- pixelDataCi.sv
`timescale 1ns/1ps
`default_nettype none

module pixelDataCi (
  input  wire                 ciStart,
  input  wire ciPkg::ciId_t   ciN,
  input  wire ciPkg::ciWord_t ciDataA,
  input  wire ciPkg::ciWord_t ciDataB,
  output logic                done,
  output ciPkg::ciWord_t      result
);

  logic           isSwap;
  logic           isGray;
  ciPkg::ciWord_t swapped;
  logic [7:0]     red8;
  logic [7:0]     green8;
  logic [7:0]     blue8;
  logic [15:0]    weightedSum;

  assign isSwap = ciStart && (ciN == ciPkg::swapByteId);
  assign isGray = ciStart && (ciN == ciPkg::grayscaleId);
  assign done   = isSwap | isGray; // Both instructions finish in their start cycle.

  // Bit 0 of the second operand selects a full byte reversal.
  assign swapped = ciDataB[0] ?
                   {ciDataA[7:0], ciDataA[15:8], ciDataA[23:16], ciDataA[31:24]} :
                   {ciDataA[15:0], ciDataA[31:16]};

  // RGB565 channels, each left-aligned to eight bits.
  assign red8   = {ciDataA[15:11], 3'b000};
  assign green8 = {ciDataA[10:5], 2'b00};
  assign blue8  = {ciDataA[4:0], 3'b000};

  // The weights add up to 256, so the sum never leaves 16 bits.
  assign weightedSum = 16'd54 * red8 + 16'd183 * green8 + 16'd19 * blue8;

  always_comb begin
    result = '0; // An unaddressed unit must keep the shared result at zero.
    if (isSwap) begin
      result = swapped;
    end else if (isGray) begin
      result = {{(ciPkg::dataWidth - 8){1'b0}}, weightedSum[15:8]};
    end
  end

endmodule

`default_nettype wire

//--- delayCi.sv
`timescale 1ns/1ps
`default_nettype none

module delayCi #(
  parameter int cyclesPerMicrosecond = 74
) (
  input  wire                 systemClock,
  input  wire                 arstN,
  input  wire                 ciStart,
  input  wire ciPkg::ciId_t   ciN,
  input  wire ciPkg::ciWord_t ciDataA,
  output logic                done,
  output ciPkg::ciWord_t      result
);

  localparam int prescaleWidth =
    (cyclesPerMicrosecond > 1) ? $clog2(cyclesPerMicrosecond) : 1;
  localparam logic [prescaleWidth-1:0] prescaleReload =
    prescaleWidth'(cyclesPerMicrosecond - 1);

  logic                     start;
  logic                     busy;
  logic [prescaleWidth-1:0] prescaler;
  ciPkg::ciWord_t           microseconds;
  logic                     tick;
  logic                     lastTick;

  assign start = ciStart && (ciN == ciPkg::delayId);
  assign tick  = (prescaler == '0); // One microsecond has elapsed.

  // A zero count ends on the first cycle after the start.
  assign lastTick = (microseconds == '0) ||
                    ((microseconds == ciPkg::ciWord_t'(1)) && tick);

  assign done   = busy && lastTick;
  assign result = '0;

  always_ff @(posedge systemClock or negedge arstN) begin
    if (!arstN) begin
      busy         <= 1'b0;
      prescaler    <= '0;
      microseconds <= '0;
    end else if (start) begin
      busy         <= 1'b1;
      prescaler    <= prescaleReload;
      microseconds <= ciDataA;
    end else if (busy) begin
      if (lastTick) begin
        busy <= 1'b0; // The processor is released in this very cycle.
      end
      if (tick) begin
        prescaler    <= prescaleReload;
        microseconds <= microseconds - 1'b1;
      end else begin
        prescaler <= prescaler - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- profileCi.sv
`timescale 1ns/1ps
`default_nettype none

module profileCi (
  input  wire                 systemClock,
  input  wire                 arstN,
  input  wire                 ciStart,
  input  wire ciPkg::ciId_t   ciN,
  input  wire ciPkg::ciWord_t ciDataA,
  input  wire ciPkg::ciWord_t ciDataB,
  input  wire                 stall,
  input  wire                 busIdle,
  output logic                done,
  output ciPkg::ciWord_t      result
);

  localparam int numCounters = 3;

  logic                   start;
  ciPkg::profileSel_t     select;
  logic [numCounters-1:0] conditions;
  logic [numCounters-1:0] enables;
  logic [numCounters-1:0] setEnables;
  logic [numCounters-1:0] clearEnables;
  logic [numCounters-1:0] clearCounters;
  ciPkg::ciWord_t         counters [numCounters];

  assign start  = ciStart && (ciN == ciPkg::profileId);
  assign select = ciDataA[1:0];
  assign done   = start;

  // Counter 0 counts every cycle, 1 the stalled ones and 2 the idle bus cycles.
  assign conditions = {busIdle, stall, 1'b1};

  assign setEnables    = start ? ciDataB[2:0] : '0;
  assign clearEnables  = start ? ciDataB[6:4] : '0;
  assign clearCounters = start ? ciDataB[10:8] : '0;

  // The read returns the value from before this cycle's update.
  always_comb begin
    result = '0;
    if (start) begin
      case (select)
        2'd0:    result = counters[0];
        2'd1:    result = counters[1];
        2'd2:    result = counters[2];
        default: result = '0;
      endcase
    end
  end

  always_ff @(posedge systemClock or negedge arstN) begin
    if (!arstN) begin
      enables <= '0;
      for (int i = 0; i < numCounters; i++) begin
        counters[i] <= '0;
      end
    end else begin
      enables <= (enables | setEnables) & ~clearEnables; // A disable beats an enable.
      for (int i = 0; i < numCounters; i++) begin
        if (clearCounters[i]) begin
          counters[i] <= '0;
        end else if (enables[i] && conditions[i]) begin
          counters[i] <= counters[i] + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- busArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module busArbiter #(
  parameter int busTimeout = 1024
) (
  input  wire                     systemClock,
  input  wire                     arstN,
  input  wire ciPkg::busRequest_t busRequests,
  input  wire                     endTransaction,
  input  wire                     dataValid,
  output ciPkg::busRequest_t      busGrants,
  output logic                    busIdle,
  output logic                    busError,
  output logic                    endTransactionOut
);

  localparam int timerWidth = $clog2(busTimeout + 1);

  logic                  granted;
  logic                  timeout;
  logic [timerWidth-1:0] watchdog;
  ciPkg::busRequest_t    nextGrant;

  assign granted = |busGrants;
  assign busIdle = ~granted;

  // A transaction that ends on its own in the timeout cycle is not an error.
  assign timeout = granted && !endTransaction &&
                   (watchdog == timerWidth'(busTimeout));

  assign busError          = timeout;
  assign endTransactionOut = timeout; // Closes the stalled transaction for all parties.

  // Fixed priority. A later, higher index overrides a lower one.
  always_comb begin
    nextGrant = '0;
    for (int i = 0; i < ciPkg::numRequesters; i++) begin
      if (busRequests[i]) begin
        nextGrant    = '0;
        nextGrant[i] = 1'b1;
      end
    end
  end

  always_ff @(posedge systemClock or negedge arstN) begin
    if (!arstN) begin
      busGrants <= '0;
      watchdog  <= '0;
    end else if (granted) begin
      if (endTransaction || timeout) begin
        busGrants <= '0; // The bus then stays idle for at least one cycle.
      end
      if (dataValid) begin
        watchdog <= timerWidth'(1);
      end else begin
        watchdog <= watchdog + 1'b1;
      end
    end else begin
      busGrants <= nextGrant;
      watchdog  <= '0;
    end
  end

endmodule

`default_nettype wire

//--- ciBusCluster.sv
`timescale 1ns/1ps
`default_nettype none

module ciBusCluster #(
  parameter int cyclesPerMicrosecond = 74,
  parameter int busTimeout           = 1024
) (
  input  wire                     systemClock,
  input  wire                     arstN,
  input  wire                     ciStart,
  input  wire ciPkg::ciId_t       ciN,
  input  wire ciPkg::ciWord_t     ciDataA,
  input  wire ciPkg::ciWord_t     ciDataB,
  input  wire                     stall,
  input  wire ciPkg::busRequest_t busRequests,
  input  wire                     endTransaction,
  input  wire                     dataValid,
  output wire                     ciDone,
  output wire ciPkg::ciWord_t     ciResult,
  output wire ciPkg::busRequest_t busGrants,
  output wire                     busIdle,
  output wire                     busError,
  output wire                     endTransactionOut
);

  wire                 pixelDone;
  wire                 delayDone;
  wire                 profileDone;
  wire ciPkg::ciWord_t pixelResult;
  wire ciPkg::ciWord_t delayResult;
  wire ciPkg::ciWord_t profileResult;

  // Units that are not addressed drive zero, so a plain OR merges them.
  assign ciDone   = pixelDone | delayDone | profileDone;
  assign ciResult = pixelResult | delayResult | profileResult;

  pixelDataCi u_pixelDataCi (
    .ciStart(ciStart),
    .ciN(ciN),
    .ciDataA(ciDataA),
    .ciDataB(ciDataB),
    .done(pixelDone),
    .result(pixelResult)
  );

  delayCi #(
    .cyclesPerMicrosecond(cyclesPerMicrosecond)
  ) u_delayCi (
    .systemClock(systemClock),
    .arstN(arstN),
    .ciStart(ciStart),
    .ciN(ciN),
    .ciDataA(ciDataA),
    .done(delayDone),
    .result(delayResult)
  );

  profileCi u_profileCi (
    .systemClock(systemClock),
    .arstN(arstN),
    .ciStart(ciStart),
    .ciN(ciN),
    .ciDataA(ciDataA),
    .ciDataB(ciDataB),
    .stall(stall),
    .busIdle(busIdle), // Idle cycles of the arbiter are profiled.
    .done(profileDone),
    .result(profileResult)
  );

  busArbiter #(
    .busTimeout(busTimeout)
  ) u_busArbiter (
    .systemClock(systemClock),
    .arstN(arstN),
    .busRequests(busRequests),
    .endTransaction(endTransaction),
    .dataValid(dataValid),
    .busGrants(busGrants),
    .busIdle(busIdle),
    .busError(busError),
    .endTransactionOut(endTransactionOut)
  );

endmodule

`default_nettype wire

//--- tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
  parameter int periodNs    = 10,
  parameter int resetCycles = 4
) (
  output logic systemClock,
  output logic arstN
);

  initial begin
    systemClock = 1'b0;
    forever #(periodNs / 2) systemClock = ~systemClock;
  end

  // Reset is released on a rising edge, after the flops have seen it low.
  initial begin
    arstN = 1'b0;
    repeat (resetCycles) @(posedge systemClock);
    arstN <= 1'b1;
  end

endmodule

`default_nettype wire

//--- tbCiBusCluster.sv
`timescale 1ns/1ps
`default_nettype none

module tbCiBusCluster;

  localparam int cyclesPerMicrosecond = 3;
  localparam int busTimeout           = 16;
  // Worst-case cycles of the six tests, in order.
  localparam int testCycles = 120 + 110 + 700 + 320 + 220 + 120;
  localparam int cycleLimit = testCycles + 2000;

  logic               systemClock;
  logic               arstN;
  logic               ciStart;
  ciPkg::ciId_t       ciN;
  ciPkg::ciWord_t     ciDataA;
  ciPkg::ciWord_t     ciDataB;
  logic               stall;
  ciPkg::busRequest_t busRequests;
  logic               endTransaction;
  logic               dataValid;
  wire                ciDone;
  wire ciPkg::ciWord_t     ciResult;
  wire ciPkg::busRequest_t busGrants;
  wire                busIdle;
  wire                busError;
  wire                endTransactionOut;

  int seed = 32'hf347;
  int errorCount = 0;
  int testErrorBase = 0;
  int testsRun = 0;
  int passedTests = 0;
  int failedTests = 0;
  int cycleCount = 0;

  // Reference model of the arbiter and the profiler.
  ciPkg::busRequest_t modelGrant;
  int                 modelAge;
  logic [2:0]         modelEnables;
  ciPkg::ciWord_t     modelCount [3];
  wire                modelIdle;
  wire                modelError;
  wire                modelProfileStart;
  wire [2:0]          modelConditions;

  logic [31:0]    wordA;
  logic [31:0]    wordB;
  logic [31:0]    readValue;
  ciPkg::ciId_t   unknownId;
  int             delayCount;
  int             expectedWait;
  int             waited;
  int             runLength;
  logic           busyRun;
  int             grantsSeen;
  logic           idleBefore;

  tbClock u_tbClock (
    .systemClock(systemClock),
    .arstN(arstN)
  );

  ciBusCluster #(
    .cyclesPerMicrosecond(cyclesPerMicrosecond),
    .busTimeout(busTimeout)
  ) u_ciBusCluster (
    .systemClock(systemClock),
    .arstN(arstN),
    .ciStart(ciStart),
    .ciN(ciN),
    .ciDataA(ciDataA),
    .ciDataB(ciDataB),
    .stall(stall),
    .busRequests(busRequests),
    .endTransaction(endTransaction),
    .dataValid(dataValid),
    .ciDone(ciDone),
    .ciResult(ciResult),
    .busGrants(busGrants),
    .busIdle(busIdle),
    .busError(busError),
    .endTransactionOut(endTransactionOut)
  );

  function automatic ciPkg::busRequest_t highestRequest(input ciPkg::busRequest_t requests);
    ciPkg::busRequest_t grant;
    grant = '0;
    for (int i = ciPkg::numRequesters - 1; i >= 0; i--) begin
      if (requests[i] && grant == '0) begin
        grant[i] = 1'b1;
      end
    end
    return grant;
  endfunction

  function automatic ciPkg::ciWord_t expectSwap(input ciPkg::ciWord_t word,
                                                input ciPkg::ciWord_t control);
    ciPkg::ciWord_t swapped;
    if (control[0]) begin
      for (int i = 0; i < 4; i++) begin
        swapped[8*i +: 8] = word[8*(3-i) +: 8];
      end
    end else begin
      swapped = {word[15:0], word[31:16]};
    end
    return swapped;
  endfunction

  function automatic ciPkg::ciWord_t expectGray(input logic [15:0] pixel);
    int red;
    int green;
    int blue;
    int sum;
    red   = int'(pixel[15:11]) * 8;
    green = int'(pixel[10:5]) * 4;
    blue  = int'(pixel[4:0]) * 8;
    sum   = 54 * red + 183 * green + 19 * blue;
    return 32'(sum / 256);
  endfunction

  task automatic reportMismatch(input string signalName, input logic [31:0] actual,
                                input logic [31:0] expected);
    $display("Fail %s: got 0x%h, expected 0x%h at %0t", signalName, actual, expected, $time);
    errorCount++;
  endtask

  task automatic reportFailure(input string message);
    $display("Error: %s at %0t", message, $time);
    errorCount++;
  endtask

  task automatic endTest(input string testName);
    int found;
    found = errorCount - testErrorBase;
    testsRun++;
    if (found == 0) begin
      passedTests++;
      $display("Test %0d (%s): passed", testsRun, testName);
    end else begin
      failedTests++;
      $display("Test %0d (%s): failed with %0d errors", testsRun, testName, found);
    end
    testErrorBase = errorCount;
  endtask

  task automatic startInstruction(input ciPkg::ciId_t id, input ciPkg::ciWord_t valueA,
                                  input ciPkg::ciWord_t valueB);
    @(posedge systemClock);
    ciStart <= 1'b1;
    ciN     <= id;
    ciDataA <= valueA;
    ciDataB <= valueB;
    @(negedge systemClock); // Outputs have settled half a cycle later.
  endtask

  task automatic clearStart();
    @(posedge systemClock);
    ciStart <= 1'b0;
  endtask

  task automatic checkQuiet();
    if (ciDone !== 1'b0) reportMismatch("ciDone", 32'(ciDone), 32'd0);
    if (ciResult !== '0) reportMismatch("ciResult", ciResult, 32'd0);
  endtask

  task automatic readCounter(input int sel, input logic [31:0] control,
                             output logic [31:0] value);
    logic [31:0] expected;
    startInstruction(ciPkg::profileId, 32'(sel), control);
    expected = (sel < 3) ? modelCount[sel] : '0;
    value = ciResult;
    if (ciDone !== 1'b1) reportMismatch("ciDone", 32'(ciDone), 32'd1);
    if (ciResult !== expected) begin
      reportMismatch($sformatf("ciResult counter %0d", sel), ciResult, expected);
    end
    clearStart();
  endtask

  task automatic runWatchdog(input logic withRestart);
    logic [31:0] randomWord;
    int restartAt;
    int elapsed;
    int errorAt;
    int grantWait;
    randomWord = $random(seed);
    restartAt  = withRestart ? 2 + int'(randomWord[7:0] % 8'd11) : -1;
    errorAt    = -1;
    elapsed    = 0;
    grantWait  = 0;
    @(posedge systemClock);
    busRequests <= randomWord[12:8] | 5'b00001;
    do begin
      @(negedge systemClock);
      grantWait++;
    end while (busIdle && grantWait < 5);
    if (busIdle) begin
      reportFailure("no grant for the watchdog transaction");
    end else begin
      // Cycle 0 is the first cycle of the grant.
      while (errorAt < 0 && elapsed < 40) begin
        @(posedge systemClock);
        busRequests <= '0;
        dataValid   <= (elapsed + 1 == restartAt);
        @(negedge systemClock);
        elapsed++;
        if (busError) begin
          errorAt = elapsed;
          if (endTransactionOut !== 1'b1) begin
            reportMismatch("endTransactionOut", 32'(endTransactionOut), 32'd1);
          end
        end
      end
      if (errorAt < 0) begin
        reportFailure("watchdog never raised busError");
      end else begin
        if (errorAt != ((restartAt > 0) ? restartAt + busTimeout : busTimeout)) begin
          reportMismatch("busError cycle", 32'(errorAt),
                         32'((restartAt > 0) ? restartAt + busTimeout : busTimeout));
        end
        @(negedge systemClock);
        if (busGrants !== '0) reportMismatch("busGrants", 32'(busGrants), 32'd0);
      end
    end
  endtask

  assign modelIdle         = (modelGrant == '0);
  assign modelError        = !modelIdle && !endTransaction && (modelAge == busTimeout);
  assign modelProfileStart = ciStart && (ciN == ciPkg::profileId);
  assign modelConditions   = {modelIdle, stall, 1'b1};

  always @(posedge systemClock or negedge arstN) begin
    if (!arstN) begin
      modelGrant   <= '0;
      modelAge     <= 0;
      modelEnables <= '0;
      for (int i = 0; i < 3; i++) begin
        modelCount[i] <= '0;
      end
    end else begin
      if (modelIdle) begin
        modelGrant <= highestRequest(busRequests);
        modelAge   <= 0;
      end else begin
        if (endTransaction || modelAge == busTimeout) begin
          modelGrant <= '0;
        end
        modelAge <= dataValid ? 1 : modelAge + 1; // Cycles since grant or last data.
      end
      for (int i = 0; i < 3; i++) begin
        if (modelProfileStart && ciDataB[8 + i]) begin
          modelCount[i] <= '0;
        end else if (modelEnables[i] && modelConditions[i]) begin
          modelCount[i] <= modelCount[i] + 32'd1;
        end
        if (modelProfileStart && ciDataB[4 + i]) begin
          modelEnables[i] <= 1'b0;
        end else if (modelProfileStart && ciDataB[i]) begin
          modelEnables[i] <= 1'b1;
        end
      end
    end
  end

  // The arbiter outputs are compared with the model in every cycle.
  always @(negedge systemClock) begin
    if (arstN) begin
      if (busGrants !== modelGrant) reportMismatch("busGrants", 32'(busGrants), 32'(modelGrant));
      if (busIdle !== modelIdle) reportMismatch("busIdle", 32'(busIdle), 32'(modelIdle));
      if (busError !== modelError) reportMismatch("busError", 32'(busError), 32'(modelError));
      if (endTransactionOut !== modelError) begin
        reportMismatch("endTransactionOut", 32'(endTransactionOut), 32'(modelError));
      end
    end
  end

  initial begin
    while (cycleCount < cycleLimit) begin
      @(posedge systemClock);
      cycleCount++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    ciStart        <= 1'b0;
    ciN            <= '0;
    ciDataA        <= '0;
    ciDataB        <= '0;
    stall          <= 1'b0;
    busRequests    <= '0;
    endTransaction <= 1'b0;
    dataValid      <= 1'b0;
    wait (arstN == 1'b1);
    @(negedge systemClock);

    for (int n = 0; n < 50; n++) begin
      wordA = $random(seed);
      wordB = $random(seed);
      startInstruction(ciPkg::swapByteId, wordA, wordB);
      if (ciDone !== 1'b1) reportMismatch("ciDone", 32'(ciDone), 32'd1);
      if (ciResult !== expectSwap(wordA, wordB)) begin
        reportMismatch("ciResult", ciResult, expectSwap(wordA, wordB));
      end
      clearStart();
    end
    do begin
      wordA = $random(seed);
      unknownId = wordA[7:0];
    end while (unknownId == ciPkg::swapByteId || unknownId == ciPkg::delayId ||
               unknownId == ciPkg::grayscaleId || unknownId == ciPkg::profileId);
    startInstruction(unknownId, wordA, wordB);
    checkQuiet();
    clearStart();
    @(negedge systemClock);
    checkQuiet();
    @(negedge systemClock);
    checkQuiet();
    endTest("byte swap");

    for (int n = 0; n < 50; n++) begin
      wordA = $random(seed);
      startInstruction(ciPkg::grayscaleId, wordA, 32'd0);
      if (ciDone !== 1'b1) reportMismatch("ciDone", 32'(ciDone), 32'd1);
      if (ciResult !== expectGray(wordA[15:0])) begin
        reportMismatch("ciResult", ciResult, expectGray(wordA[15:0]));
      end
      clearStart();
    end
    endTest("grayscale");

    for (int n = 0; n < 20; n++) begin
      wordA = $random(seed);
      delayCount   = (n == 0) ? 0 : int'(wordA[7:0] % 8'd11);
      expectedWait = (delayCount == 0) ? 1 : delayCount * cyclesPerMicrosecond;
      startInstruction(ciPkg::delayId, 32'(delayCount), wordA);
      if (ciDone !== 1'b0) reportFailure("delay done came in its start cycle");
      clearStart();
      waited = 0;
      do begin
        @(negedge systemClock);
        waited++;
      end while (!ciDone && waited < 40);
      if (!ciDone) begin
        reportFailure("delay instruction gave no done within 40 cycles");
      end else begin
        if (waited != expectedWait) begin
          reportMismatch("ciDone latency", 32'(waited), 32'(expectedWait));
        end
        if (ciResult !== '0) reportMismatch("ciResult", ciResult, 32'd0);
        @(negedge systemClock);
        if (ciDone !== 1'b0) reportFailure("delay done lasted more than one cycle");
      end
    end
    endTest("delay");

    readCounter(0, 32'h0000_0707, readValue); // Clear and enable all three counters.
    for (int run = 0; run < 8; run++) begin
      wordA = $random(seed);
      runLength = 4 + int'(wordA[15:0] % 16'd21);
      busyRun   = wordA[16];
      for (int c = 0; c < runLength; c++) begin
        wordB = $random(seed);
        @(posedge systemClock);
        stall          <= wordB[0];
        busRequests    <= busyRun ? (wordB[5:1] | 5'b00001) : '0;
        endTransaction <= !busyRun && (c == 0);
      end
      for (int sel = 0; sel < 4; sel++) begin
        readCounter(sel, 32'd0, readValue);
      end
    end
    readCounter(0, 32'h0000_0770, readValue);
    for (int sel = 0; sel < 3; sel++) begin
      readCounter(sel, 32'd0, readValue);
      if (readValue !== '0) begin
        reportMismatch($sformatf("counter %0d after clear", sel), readValue, 0);
      end
    end
    endTest("profiler");

    grantsSeen = 0;
    idleBefore = 1'b1;
    for (int c = 0; c < 200; c++) begin
      wordA = $random(seed);
      @(posedge systemClock);
      if (wordA[1:0] == 2'b00) begin
        busRequests <= wordA[6:2];
      end
      endTransaction <= (wordA[8:7] == 2'b00);
      dataValid      <= wordA[9];
      @(negedge systemClock);
      if (!busIdle && idleBefore) grantsSeen++;
      idleBefore = busIdle;
      if ((busGrants & (busGrants - 1'b1)) != '0) reportFailure("busGrants is not one-hot");
    end
    @(posedge systemClock);
    busRequests    <= '0;
    endTransaction <= 1'b1; // Releases any grant still held.
    dataValid      <= 1'b0;
    @(posedge systemClock);
    endTransaction <= 1'b0;
    if (grantsSeen == 0) reportFailure("no grant during random arbitration");
    endTest("arbitration");

    runWatchdog(1'b0);
    runWatchdog(1'b1);
    endTest("watchdog");

    $display("Tests: %0d run, %0d passed, %0d failed, %0d errors",
             testsRun, passedTests, failedTests, errorCount);
    if (errorCount == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
ciPkg.sv
pixelDataCi.sv
delayCi.sv
profileCi.sv
busArbiter.sv
ciBusCluster.sv
tbClock.sv
tbCiBusCluster.sv

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
  --top-module tbCiBusCluster -f filelist.f -o simCiBusCluster

./obj_dir/simCiBusCluster | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
  echo "Simulation reported errors"
  exit 1
fi
echo "Simulation finished without errors"
